// ==== hart_isa_pkg.sv ====
/*
 * RV32I instruction encoding constants: opcodes, funct3 codes for
 * branches and memory sizes, the EBREAK word and register file size
 */
package hart_isa_pkg;

    // ==================================================
    // Major opcodes
    // ==================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Reg-reg ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Reg-imm ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ECALL, EBREAK, CSR

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load/store access size, bit 2 set means zero extend
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

endpackage

// ==== hart_ctrl_pkg.sv ====
/*
 * Internal control encodings from the decoder to the datapath:
 * immediate format, ALU operation, result select and flow class
 */
package hart_ctrl_pkg;

    // Immediate layout per instruction format
    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE
    } imm_fmt_e;

    // Ordered like funct3 of OP/OP-IMM so the decoder can cast directly
    typedef enum logic [2:0] {
        ALU_ADD,  // Also SUB
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,  // Also SRA
        ALU_OR,
        ALU_AND
    } alu_opsel_e;

    // Non-memory write-back source
    typedef enum logic [1:0] {
        RES_ALU, RES_IMM, RES_PC_IMM, RES_PC4
    } res_sel_e;

    // Control flow class
    typedef enum logic [1:0] {
        FLOW_SEQ, FLOW_BRANCH, FLOW_JAL, FLOW_JALR
    } branch_kind_e;

endpackage

// ==== fetch_unit.sv ====
/*
 * Program counter, sticky halted state, branch decision
 * and next-PC selection
 */
`timescale 1ns/1ps

module fetch_unit
    import hart_isa_pkg::*;
    import hart_ctrl_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic         i_clk,
    input  logic         i_rst,
    input  branch_kind_e i_flow,
    input  logic [2:0]   i_funct3,
    input  logic         i_alu_eq,
    input  logic         i_alu_lt,     // Signed or unsigned per decoder
    input  logic [31:0]  i_imm,
    input  logic [31:0]  i_rs1_data,
    input  logic         i_halt_req,   // EBREAK or illegal opcode
    output logic [31:0]  o_pc,
    output logic [31:0]  o_pc_plus4,
    output logic [31:0]  o_next_pc,
    output logic         o_run
);

    logic        halted_q;
    logic        taken;
    logic [31:0] target;

    // Branch condition from funct3 and ALU flags
    always_comb begin
        case (i_funct3)
            F3_BEQ:  taken = i_alu_eq;
            F3_BNE:  taken = !i_alu_eq;
            F3_BLT:  taken = i_alu_lt;
            F3_BGE:  taken = !i_alu_lt;
            F3_BLTU: taken = i_alu_lt;
            F3_BGEU: taken = !i_alu_lt;
            default: taken = 1'b0;
        endcase
    end

    // Next PC
    always_comb begin
        case (i_flow)
            FLOW_JALR:   target = (i_rs1_data + i_imm) & ~32'd1; // LSB cleared
            FLOW_JAL:    target = o_pc + i_imm;
            FLOW_BRANCH: target = taken ? o_pc + i_imm : o_pc_plus4;
            default:     target = o_pc_plus4;
        endcase
    end

    assign o_pc_plus4 = o_pc + 32'd4;
    assign o_next_pc  = i_halt_req ? o_pc : target; // Halting instruction stays put
    assign o_run      = !i_rst && !halted_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc     <= RESET_ADDR;
            halted_q <= 1'b0;
        end else if (o_run) begin
            o_pc     <= o_next_pc;
            halted_q <= i_halt_req;  // Sticky until reset
        end
    end

endmodule

// ==== decoder.sv ====
/*
 * Instruction decoder: field split, main control, immediate
 * generation, ALU control and trap/halt detection
 */
`timescale 1ns/1ps

module decoder
    import hart_isa_pkg::*;
    import hart_ctrl_pkg::*;
(
    input  logic [31:0]           i_inst,
    input  logic                  i_run,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output logic [REG_ADDR_W-1:0] o_rd_addr,
    output logic [2:0]            o_funct3,
    output logic [31:0]           o_imm,
    output alu_opsel_e            o_alu_opsel,
    output logic                  o_alu_sub,
    output logic                  o_alu_unsigned,
    output logic                  o_alu_arith,
    output logic                  o_alu_src_imm,
    output res_sel_e              o_res_sel,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_reg_write,   // Already gated by run and halt
    output branch_kind_e          o_flow,
    output logic                  o_trap,
    output logic                  o_halt_req
);

    logic [6:0] opcode;
    logic       f7_bit5;
    logic       is_op, is_op_imm, is_branch;
    logic       writes_rd;
    imm_fmt_e   imm_fmt;

    assign opcode     = i_inst[6:0];
    assign o_funct3   = i_inst[14:12];
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];
    assign f7_bit5    = i_inst[30];

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_branch = (opcode == OPC_BRANCH);

    // ==================================================
    // Main control
    // ==================================================
    always_comb begin
        writes_rd     = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_alu_src_imm = 1'b0;
        o_res_sel     = RES_ALU;
        o_flow        = FLOW_SEQ;
        imm_fmt       = IMM_NONE;
        o_trap        = 1'b0;
        case (opcode)
            OPC_OP:     writes_rd = 1'b1;
            OPC_OP_IMM: begin writes_rd = 1'b1; o_alu_src_imm = 1'b1; imm_fmt = IMM_I; end
            OPC_LOAD: begin
                writes_rd     = 1'b1;
                o_mem_read    = 1'b1;
                o_alu_src_imm = 1'b1;
                imm_fmt       = IMM_I;
            end
            OPC_STORE:  begin o_mem_write = 1'b1; o_alu_src_imm = 1'b1; imm_fmt = IMM_S; end
            OPC_BRANCH: begin o_flow = FLOW_BRANCH; imm_fmt = IMM_B; end // Compare rs1, rs2
            OPC_JAL: begin
                writes_rd = 1'b1;
                o_res_sel = RES_PC4;   // Link
                o_flow    = FLOW_JAL;
                imm_fmt   = IMM_J;
            end
            OPC_JALR: begin
                writes_rd = 1'b1;
                o_res_sel = RES_PC4;
                o_flow    = FLOW_JALR;
                imm_fmt   = IMM_I;
            end
            OPC_LUI:    begin writes_rd = 1'b1; o_res_sel = RES_IMM;    imm_fmt = IMM_U; end
            OPC_AUIPC:  begin writes_rd = 1'b1; o_res_sel = RES_PC_IMM; imm_fmt = IMM_U; end
            OPC_SYSTEM: ;                  // Only EBREAK acts, rest are no-ops
            default:    o_trap = 1'b1;     // Unsupported opcode
        endcase
    end

    // Immediate, sign extended
    always_comb begin
        case (imm_fmt)
            IMM_I:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            IMM_S:   o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            IMM_B:   o_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            IMM_U:   o_imm = {i_inst[31:12], 12'b0};
            IMM_J:   o_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            default: o_imm = 32'd0;
        endcase
    end

    // ==================================================
    // ALU control
    // ==================================================
    assign o_alu_opsel    = (is_op || is_op_imm) ? alu_opsel_e'(o_funct3) : ALU_ADD;
    assign o_alu_sub      = is_op && f7_bit5 && (o_funct3 == 3'b000);  // SUB only
    assign o_alu_arith    = (is_op || is_op_imm) && f7_bit5 && (o_funct3 == 3'b101);
    assign o_alu_unsigned = (is_branch && o_funct3[1])                  // BLTU, BGEU
                         || ((is_op || is_op_imm) && o_funct3 == 3'b011); // SLTU(I)

    // Halt and gated register write
    assign o_halt_req  = o_trap || (i_inst == INST_EBREAK);
    assign o_reg_write = writes_rd && i_run && !o_halt_req;
    assign o_rd_addr   = o_reg_write ? i_inst[11:7] : '0;

endmodule

// ==== reg_file.sv ====
/*
 * 32 x 32-bit register file, two combinational reads,
 * one write at the clock edge, x0 reads as zero
 */
`timescale 1ns/1ps

module reg_file
    import hart_isa_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic [31:0]           i_rd_wdata,
    input  logic                  i_rd_wen,
    output logic [31:0]           o_rs1_data,
    output logic [31:0]           o_rs2_data
);

    logic [31:0] regs [1:NUM_REGS-1]; // No storage for x0

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? 32'd0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? 32'd0 : regs[i_rs2_addr];

endmodule

// ==== execute_unit.sv ====
/*
 * ALU with equal and less-than flags, plus the
 * non-memory result select (ALU, LUI, AUIPC, link)
 */
`timescale 1ns/1ps

module execute_unit
    import hart_ctrl_pkg::*;
(
    input  alu_opsel_e  i_opsel,
    input  logic        i_sub,
    input  logic        i_unsigned,
    input  logic        i_arith,
    input  logic        i_src_imm,
    input  logic [31:0] i_rs1_data,
    input  logic [31:0] i_rs2_data,
    input  logic [31:0] i_imm,
    input  logic [31:0] i_pc,
    input  logic [31:0] i_pc_plus4,
    input  res_sel_e    i_res_sel,
    output logic [31:0] o_alu_result,
    output logic        o_eq,
    output logic        o_lt,
    output logic [31:0] o_result
);

    logic [31:0] op2;
    logic [4:0]  shamt;

    assign op2   = i_src_imm ? i_imm : i_rs2_data;
    assign shamt = op2[4:0];

    // Flags, shared by SLT(U) and branches
    assign o_eq = (i_rs1_data == op2);
    assign o_lt = i_unsigned ? (i_rs1_data < op2)
                             : ($signed(i_rs1_data) < $signed(op2));

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (i_opsel)
            ALU_ADD:  o_alu_result = i_sub ? i_rs1_data - op2 : i_rs1_data + op2;
            ALU_SLL:  o_alu_result = i_rs1_data << shamt;
            ALU_SLT,
            ALU_SLTU: o_alu_result = {31'd0, o_lt};       // Sign mode set by decoder
            ALU_XOR:  o_alu_result = i_rs1_data ^ op2;
            ALU_SRL:  o_alu_result = i_arith ? 32'($signed(i_rs1_data) >>> shamt)
                                             : i_rs1_data >> shamt;
            ALU_OR:   o_alu_result = i_rs1_data | op2;
            ALU_AND:  o_alu_result = i_rs1_data & op2;
            default:  o_alu_result = 32'd0;
        endcase
    end

    // Result for everything except loads
    always_comb begin
        case (i_res_sel)
            RES_IMM:    o_result = i_imm;          // LUI
            RES_PC_IMM: o_result = i_pc + i_imm;   // AUIPC
            RES_PC4:    o_result = i_pc_plus4;     // JAL, JALR
            default:    o_result = o_alu_result;
        endcase
    end

endmodule

// ==== lsu.sv ====
/*
 * Load/store unit: word alignment, store lane steering and mask,
 * load extraction with extension, final write-back select
 */
`timescale 1ns/1ps

module lsu
    import hart_isa_pkg::*;
(
    input  logic [31:0] i_addr,        // rs1 + imm from the ALU
    input  logic [2:0]  i_funct3,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  logic [31:0] i_rs2_data,
    input  logic [31:0] i_dmem_rdata,
    input  logic [31:0] i_result,
    input  logic        i_run,
    input  logic        i_halt_req,
    output logic [31:0] o_dmem_addr,
    output logic        o_dmem_ren,
    output logic        o_dmem_wen,
    output logic [31:0] o_dmem_wdata,
    output logic [3:0]  o_dmem_mask,
    output logic [31:0] o_rd_wdata
);

    logic [1:0]  offset;
    logic [31:0] rdata_shifted;
    logic [31:0] load_data;

    assign offset      = i_addr[1:0];
    assign o_dmem_addr = {i_addr[31:2], 2'b00};

    // No access in reset, when halted or on the halting instruction
    assign o_dmem_ren = i_mem_read && i_run && !i_halt_req;
    assign o_dmem_wen = i_mem_write && i_run && !i_halt_req;

    // Store lanes and mask
    assign o_dmem_wdata = i_rs2_data << {offset, 3'b000};

    always_comb begin
        case (i_funct3)
            F3_B:    o_dmem_mask = 4'b0001 << offset;
            F3_H:    o_dmem_mask = 4'b0011 << offset;
            default: o_dmem_mask = 4'b1111;
        endcase
    end

    // Addressed byte/half moved to bit 0, then extended
    assign rdata_shifted = i_dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (i_funct3)
            F3_B:    load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            F3_H:    load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            F3_BU:   load_data = {24'd0, rdata_shifted[7:0]};
            F3_HU:   load_data = {16'd0, rdata_shifted[15:0]};
            F3_W:    load_data = i_dmem_rdata;
            default: load_data = i_dmem_rdata;
        endcase
    end

    assign o_rd_wdata = i_mem_read ? load_data : i_result;

endmodule

// ==== hart_top.sv ====
/*
 * Single-cycle RV32I hart: fetch unit, decoder, register file,
 * execute unit and load/store unit with a per-instruction retire port
 */
`timescale 1ns/1ps

module hart_top
    import hart_isa_pkg::*;
    import hart_ctrl_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic        i_clk,
    input  logic        i_rst,
    // Instruction memory, combinational read
    output logic [31:0] o_imem_raddr,
    input  logic [31:0] i_imem_rdata,
    // Data memory, write lands at next edge
    output logic [31:0] o_dmem_addr,
    output logic        o_dmem_ren,
    output logic        o_dmem_wen,
    output logic [31:0] o_dmem_wdata,
    output logic [3:0]  o_dmem_mask,
    input  logic [31:0] i_dmem_rdata,
    // Retire, same cycle as the PC
    output logic        o_retire_valid,
    output logic [31:0] o_retire_inst,
    output logic [31:0] o_retire_pc,
    output logic [31:0] o_retire_next_pc,
    output logic [4:0]  o_retire_rd_waddr,
    output logic [31:0] o_retire_rd_wdata,
    output logic        o_retire_trap,
    output logic        o_retire_halt
);

    // ==================================================
    // Interconnect
    // ==================================================
    logic [31:0]           pc, pc_plus4, next_pc;
    logic                  run;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [2:0]            funct3;
    logic [31:0]           imm;
    alu_opsel_e            alu_opsel;
    logic                  alu_sub, alu_unsigned, alu_arith, alu_src_imm;
    res_sel_e              res_sel;
    logic                  mem_read, mem_write, reg_write;
    branch_kind_e          flow;
    logic                  trap, halt_req;
    logic [31:0]           rs1_data, rs2_data;
    logic [31:0]           alu_result, result, rd_wdata;
    logic                  alu_eq, alu_lt;

    fetch_unit #(
        .RESET_ADDR (RESET_ADDR)
    ) fetch_unit_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_flow     (flow),
        .i_funct3   (funct3),
        .i_alu_eq   (alu_eq),
        .i_alu_lt   (alu_lt),
        .i_imm      (imm),
        .i_rs1_data (rs1_data),
        .i_halt_req (halt_req),
        .o_pc       (pc),
        .o_pc_plus4 (pc_plus4),
        .o_next_pc  (next_pc),
        .o_run      (run)
    );

    decoder decoder_i (
        .i_inst         (i_imem_rdata),
        .i_run          (run),
        .o_rs1_addr     (rs1_addr),
        .o_rs2_addr     (rs2_addr),
        .o_rd_addr      (rd_addr),
        .o_funct3       (funct3),
        .o_imm          (imm),
        .o_alu_opsel    (alu_opsel),
        .o_alu_sub      (alu_sub),
        .o_alu_unsigned (alu_unsigned),
        .o_alu_arith    (alu_arith),
        .o_alu_src_imm  (alu_src_imm),
        .o_res_sel      (res_sel),
        .o_mem_read     (mem_read),
        .o_mem_write    (mem_write),
        .o_reg_write    (reg_write),
        .o_flow         (flow),
        .o_trap         (trap),
        .o_halt_req     (halt_req)
    );

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_rd_addr  (rd_addr),
        .i_rd_wdata (rd_wdata),
        .i_rd_wen   (reg_write),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit execute_unit_i (
        .i_opsel      (alu_opsel),
        .i_sub        (alu_sub),
        .i_unsigned   (alu_unsigned),
        .i_arith      (alu_arith),
        .i_src_imm    (alu_src_imm),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_imm        (imm),
        .i_pc         (pc),
        .i_pc_plus4   (pc_plus4),
        .i_res_sel    (res_sel),
        .o_alu_result (alu_result),
        .o_eq         (alu_eq),
        .o_lt         (alu_lt),
        .o_result     (result)
    );

    lsu lsu_i (
        .i_addr       (alu_result),
        .i_funct3     (funct3),
        .i_mem_read   (mem_read),
        .i_mem_write  (mem_write),
        .i_rs2_data   (rs2_data),
        .i_dmem_rdata (i_dmem_rdata),
        .i_result     (result),
        .i_run        (run),
        .i_halt_req   (halt_req),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_mask  (o_dmem_mask),
        .o_rd_wdata   (rd_wdata)
    );

    // ==================================================
    // Fetch address and retire port
    // ==================================================
    assign o_imem_raddr      = pc;
    assign o_retire_valid    = run;          // Low in reset and once halted
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = next_pc;
    assign o_retire_rd_waddr = rd_addr;      // Zero when nothing is written
    assign o_retire_rd_wdata = rd_wdata;
    assign o_retire_trap     = trap;
    assign o_retire_halt     = halt_req;

endmodule

// ==== tb_hart.sv ====
/*
 * Testbench for the single-cycle hart: instruction and data memory
 * models, golden record interpreter, retire and halt checks
 */
`timescale 1ns/1ps

module tb_hart;

    localparam logic [31:0] RESET_ADDR   = 32'h0000_0000;
    localparam int          NUM_RECS     = 128;
    localparam int          MAX_WAIT     = 20;  // Cycles allowed per retire
    localparam int          IDLE_CYCLES  = 10;  // Quiet cycles after a halt

    logic        i_clk;
    logic        i_rst;
    logic [31:0] o_imem_raddr, i_imem_rdata;
    logic [31:0] o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    logic        o_dmem_ren, o_dmem_wen;
    logic [3:0]  o_dmem_mask;
    logic        o_retire_valid, o_retire_trap, o_retire_halt;
    logic [31:0] o_retire_inst, o_retire_pc, o_retire_next_pc, o_retire_rd_wdata;
    logic [4:0]  o_retire_rd_waddr;

    logic [31:0]  imem [0:255];
    logic [31:0]  dmem [0:255];
    logic [127:0] golden [0:NUM_RECS-1];   // kind, a, b, c

    // Retire captured at the rising edge
    logic [31:0] got_inst, got_pc, got_next_pc, got_rd_wdata;
    logic [4:0]  got_rd_waddr;
    logic        got_trap, got_halt;
    int          checks_done;

    hart_top #(
        .RESET_ADDR (RESET_ADDR)
    ) hart_top_i (
        .i_clk (i_clk), .i_rst (i_rst),
        .o_imem_raddr (o_imem_raddr), .i_imem_rdata (i_imem_rdata),
        .o_dmem_addr (o_dmem_addr), .o_dmem_ren (o_dmem_ren), .o_dmem_wen (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata), .o_dmem_mask (o_dmem_mask),
        .i_dmem_rdata (i_dmem_rdata),
        .o_retire_valid (o_retire_valid), .o_retire_inst (o_retire_inst),
        .o_retire_pc (o_retire_pc), .o_retire_next_pc (o_retire_next_pc),
        .o_retire_rd_waddr (o_retire_rd_waddr), .o_retire_rd_wdata (o_retire_rd_wdata),
        .o_retire_trap (o_retire_trap), .o_retire_halt (o_retire_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;   // 8 ns period
    end

    // ==================================================
    // Memory models
    // ==================================================
    assign i_imem_rdata = imem[o_imem_raddr[9:2]];   // Combinational reads
    assign i_dmem_rdata = o_dmem_ren ? dmem[o_dmem_addr[9:2]] : 'x;  // Data only on a read

    always @(posedge i_clk) begin
        if (o_dmem_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (o_dmem_mask[b])
                    dmem[o_dmem_addr[9:2]][8*b +: 8] <= o_dmem_wdata[8*b +: 8];
            end
        end
    end

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks_done++;
        if (got !== exp) begin
            $display("error: %s = %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Three reset cycles in which nothing may retire or touch memory
    task automatic apply_reset();
        @(negedge i_clk);
        i_rst = 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(posedge i_clk);
            compare_value("o_retire_valid", 32'(o_retire_valid), 32'd0);
            compare_value("o_dmem_wen", 32'(o_dmem_wen), 32'd0);
            compare_value("o_dmem_ren", 32'(o_dmem_ren), 32'd0);
            @(negedge i_clk);
        end
        i_rst = 1'b0;
    endtask

    task automatic wait_retire();
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < MAX_WAIT) begin
            @(posedge i_clk);          // Values of the cycle that ends here
            if (o_retire_valid) begin
                found        = 1'b1;
                got_inst     = o_retire_inst;
                got_pc       = o_retire_pc;
                got_next_pc  = o_retire_next_pc;
                got_rd_waddr = o_retire_rd_waddr;
                got_rd_wdata = o_retire_rd_wdata;
                got_trap     = o_retire_trap;
                got_halt     = o_retire_halt;
            end
            cycles++;
        end
        if (!found) begin
            $display("timeout, no instruction retired within %0d cycles", MAX_WAIT);
            stop_with_failure();
        end else begin
            @(negedge i_clk);
        end
    endtask

    // Halted hart stays frozen and silent
    task automatic watch_halted_idle(input logic [31:0] halt_pc);
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(posedge i_clk);
            compare_value("o_retire_valid", 32'(o_retire_valid), 32'd0);
            compare_value("o_dmem_wen", 32'(o_dmem_wen), 32'd0);
            compare_value("o_dmem_ren", 32'(o_dmem_ren), 32'd0);
            compare_value("o_imem_raddr", o_imem_raddr, halt_pc);
        end
        @(negedge i_clk);
    endtask

    // ==================================================
    // Golden record interpreter
    // ==================================================
    initial begin
        int          idx;
        logic [31:0] kind, wa, wb, wc;
        logic [31:0] prev_next_pc;
        logic        have_prev, pending_reset, done;
        i_rst         = 1'b1;
        checks_done   = 0;
        have_prev     = 1'b0;
        pending_reset = 1'b1;
        done          = 1'b0;
        prev_next_pc  = 32'd0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[7:0], 24'h0};                   // Opcode 0 traps if fetched
            dmem[i] = {~i[7:0], i[7:0], 8'h5a, i[7:0]};
        end
        for (int i = 0; i < NUM_RECS; i++) begin
            golden[i] = '0;
        end
        $readmemh("hart_golden.hex", golden);

        for (idx = 0; idx < NUM_RECS && !done; idx++) begin
            kind = golden[idx][127:96];
            wa   = golden[idx][95:64];
            wb   = golden[idx][63:32];
            wc   = golden[idx][31:0];
            case (kind)
                32'd0: done = 1'b1;
                32'd1: imem[wa[9:2]] = wb;
                32'd2: dmem[wa[9:2]] = wb;
                32'd3, 32'd4: begin
                    if (pending_reset) begin
                        apply_reset();
                        pending_reset = 1'b0;
                        have_prev     = 1'b0;
                    end
                    wait_retire();
                    if (!have_prev)
                        compare_value("o_retire_pc", got_pc, RESET_ADDR); // First after reset
                    else
                        compare_value("o_retire_next_pc", prev_next_pc, wa);
                    compare_value("o_retire_pc", got_pc, wa);
                    compare_value("o_retire_inst", got_inst, imem[wa[9:2]]);
                    if (kind == 32'd3) begin
                        compare_value("o_retire_halt", 32'(got_halt), 32'd0);
                        compare_value("o_retire_trap", 32'(got_trap), 32'd0);
                        compare_value("o_retire_rd_waddr", 32'(got_rd_waddr), wb);
                        if (wb != 32'd0)
                            compare_value("o_retire_rd_wdata", got_rd_wdata, wc);
                    end else begin
                        compare_value("o_retire_halt", 32'(got_halt), 32'd1);
                        compare_value("o_retire_trap", 32'(got_trap), wb);
                        compare_value("o_retire_rd_waddr", 32'(got_rd_waddr), 32'd0);
                        watch_halted_idle(wa);
                    end
                    prev_next_pc = got_next_pc;
                    have_prev    = 1'b1;
                end
                32'd5: begin
                    @(negedge i_clk);
                    i_rst         = 1'b1;   // Held until the next expectation
                    pending_reset = 1'b1;
                end
                default: begin
                    $display("golden record %0d has an unknown kind %h", idx, kind);
                    stop_with_failure();
                end
            endcase
        end

        if (checks_done == 0) begin
            $display("no golden checks were run");
            stop_with_failure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== hart_golden.hex ====
// Record: kind_a_b_c, each 32 bits. 1 inst (a=addr b=word), 2 data (a=addr b=word)
// 3 retire (a=pc b=rd c=rd data), 4 halt (a=pc b=trap), 5 reset, 0 end
// Program 1: ALU, LUI, AUIPC
00000001_00000000_FFB00093_00000000
00000001_00000004_00300113_00000000
00000001_00000008_002081B3_00000000
00000001_0000000C_40110233_00000000
00000001_00000010_002112B3_00000000
00000001_00000014_0020A333_00000000
00000001_00000018_0020B3B3_00000000
00000001_0000001C_0020C433_00000000
00000001_00000020_0020D4B3_00000000
00000001_00000024_4020D533_00000000
00000001_00000028_0020E5B3_00000000
00000001_0000002C_0020F633_00000000
00000001_00000030_FFC0A693_00000000
00000001_00000034_FFF13713_00000000
00000001_00000038_0F00C793_00000000
00000001_0000003C_4010D813_00000000
00000001_00000040_00411893_00000000
00000001_00000044_00708013_00000000
00000001_00000048_00200933_00000000
00000001_0000004C_123459B7_00000000
00000001_00000050_00001A17_00000000
// Branches, taken ones skip an unloaded slot
00000001_00000054_00208463_00000000
00000001_00000058_00210463_00000000
00000001_00000060_00109463_00000000
00000001_00000064_00209463_00000000
00000001_0000006C_00114463_00000000
00000001_00000070_0020C463_00000000
00000001_00000078_0020D463_00000000
00000001_0000007C_00115463_00000000
00000001_00000084_0020E463_00000000
00000001_00000088_00116463_00000000
00000001_00000090_00117463_00000000
00000001_00000094_0020F463_00000000
// JAL, JALR with odd target
00000001_0000009C_00C00AEF_00000000
00000001_000000A8_011A8B67_00000000
// Stores, loads, EBREAK
00000001_000000B0_10000B93_00000000
00000001_000000B4_001BA023_00000000
00000001_000000B8_002B80A3_00000000
00000001_000000BC_013B9123_00000000
00000001_000000C0_001B83A3_00000000
00000001_000000C4_000BAC03_00000000
00000001_000000C8_001B8C83_00000000
00000001_000000CC_000BCD03_00000000
00000001_000000D0_007B8D83_00000000
00000001_000000D4_006B9E03_00000000
00000001_000000D8_006BDE83_00000000
00000001_000000DC_002B9F03_00000000
00000001_000000E0_004BDF83_00000000
00000001_000000E4_004BA083_00000000
00000001_000000E8_00100073_00000000
00000002_00000104_80017F80_00000000
// Expected retires
00000003_00000000_00000001_FFFFFFFB
00000003_00000004_00000002_00000003
00000003_00000008_00000003_FFFFFFFE
00000003_0000000C_00000004_00000008
00000003_00000010_00000005_00000018
00000003_00000014_00000006_00000001
00000003_00000018_00000007_00000000
00000003_0000001C_00000008_FFFFFFF8
00000003_00000020_00000009_1FFFFFFF
00000003_00000024_0000000A_FFFFFFFF
00000003_00000028_0000000B_FFFFFFFB
00000003_0000002C_0000000C_00000003
00000003_00000030_0000000D_00000001
00000003_00000034_0000000E_00000001
00000003_00000038_0000000F_FFFFFF0B
00000003_0000003C_00000010_FFFFFFFD
00000003_00000040_00000011_00000030
00000003_00000044_00000000_00000000
00000003_00000048_00000012_00000003
00000003_0000004C_00000013_12345000
00000003_00000050_00000014_00001050
00000003_00000054_00000000_00000000
00000003_00000058_00000000_00000000
00000003_00000060_00000000_00000000
00000003_00000064_00000000_00000000
00000003_0000006C_00000000_00000000
00000003_00000070_00000000_00000000
00000003_00000078_00000000_00000000
00000003_0000007C_00000000_00000000
00000003_00000084_00000000_00000000
00000003_00000088_00000000_00000000
00000003_00000090_00000000_00000000
00000003_00000094_00000000_00000000
00000003_0000009C_00000015_000000A0
00000003_000000A8_00000016_000000AC
00000003_000000B0_00000017_00000100
00000003_000000B4_00000000_00000000
00000003_000000B8_00000000_00000000
00000003_000000BC_00000000_00000000
00000003_000000C0_00000000_00000000
00000003_000000C4_00000018_500003FB
00000003_000000C8_00000019_00000003
00000003_000000CC_0000001A_000000FB
00000003_000000D0_0000001B_FFFFFFFB
00000003_000000D4_0000001C_FFFFFB01
00000003_000000D8_0000001D_0000FB01
00000003_000000DC_0000001E_00005000
00000003_000000E0_0000001F_00007F80
00000003_000000E4_00000001_FB017F80
00000004_000000E8_00000000_00000000
// Program 2: illegal opcode traps
00000005_00000000_00000000_00000000
00000001_00000000_00100293_00000000
00000001_00000004_FFFFFFFF_00000000
00000003_00000000_00000005_00000001
00000004_00000004_00000001_00000000
00000000_00000000_00000000_00000000

// ==== verilog.f ====
hart_isa_pkg.sv
hart_ctrl_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
execute_unit.sv
lsu.sv
hart_top.sv
tb_hart.sv

// ==== Bender.yml ====
package:
  name: hart

sources:
  - hart_isa_pkg.sv
  - hart_ctrl_pkg.sv
  - fetch_unit.sv
  - decoder.sv
  - reg_file.sv
  - execute_unit.sv
  - lsu.sv
  - hart_top.sv
  - target: simulation
    files:
      - tb_hart.sv
